/* hw/video_pkg.sv */
package video_pkg;

	localparam int H_ACTIVE = 32;                                 // visible pixels per line
	localparam int H_FRONT  = 2;
	localparam int H_SYNC   = 4;                                  // hsync low width
	localparam int H_BACK   = 2;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 40 clocks per line

	localparam int V_ACTIVE = 24;                                 // visible lines
	localparam int V_FRONT  = 1;
	localparam int V_SYNC   = 2;                                  // vsync low width in lines
	localparam int V_BACK   = 1;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 28 lines per frame

	localparam int PIXEL_LATENCY = 2;                             // count -> rgb and syncs

	localparam int SPRITE_SLOTS = 4;
	localparam int SPRITE_SIZE  = 8;                              // 8x8 image
	localparam int MEM_DEPTH    = 256;                            // 4 images x 64 words

	typedef logic [8:0] color_t;                                  // rrr ggg bbb
	typedef logic [5:0] hpos_t;
	typedef logic [4:0] vpos_t;
	typedef logic [4:0] reg_num_t;
	typedef logic [7:0] mem_addr_t;

	localparam hpos_t H_LAST       = hpos_t'(H_TOTAL - 1);        // wrap point
	localparam hpos_t H_SYNC_START = hpos_t'(H_ACTIVE + H_FRONT); // 34
	localparam hpos_t H_SYNC_END   = hpos_t'(H_ACTIVE + H_FRONT + H_SYNC); // 38, exclusive
	localparam vpos_t V_LAST       = vpos_t'(V_TOTAL - 1);
	localparam vpos_t V_SYNC_START = vpos_t'(V_ACTIVE + V_FRONT); // 25
	localparam vpos_t V_SYNC_END   = vpos_t'(V_ACTIVE + V_FRONT + V_SYNC); // 27, exclusive

	localparam reg_num_t REG_BG = '0;                             // background colour register

	typedef enum logic [1:0] {
		OP_WBR  = 2'd0,                                           // write register
		OP_WSM  = 2'd1,                                           // write sprite memory
		OP_NOP2 = 2'd2,
		OP_NOP3 = 2'd3
	} opcode_e;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_BLANK,                                               // hold until screen blanks
		WRITE,
		DONE
	} ctrl_state_e;

	// msb first so data_b[13:0] maps straight onto it
	typedef struct packed {
		logic       enable;                                       // bit 13
		logic [1:0] image;                                        // bits 12:11, 64-word block
		vpos_t      y;                                            // bits 10:6
		hpos_t      x;                                            // bits 5:0
	} sprite_t;

	typedef struct packed {
		opcode_e     opcode;
		reg_num_t    reg_num;                                     // only meaningful for OP_WBR
		mem_addr_t   mem_addr;                                    // only meaningful for OP_WSM
		logic [31:0] payload;                                     // raw data_b
	} instr_t;

endpackage

/* hw/instruction_decoder.sv */
module instruction_decoder import video_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        instr_valid,                 // one-cycle host strobe
	input  logic [31:0] data_a,
	input  logic [31:0] data_b,
	input  logic        instr_done,                  // from control unit
	output instr_t      instr,
	output logic        pending
);

	logic capture;

	assign capture = instr_valid && !pending;        // strobes while busy are dropped

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else if (capture) begin
			pending <= 1'b1;                         // seen by control next cycle
		end else if (instr_done) begin
			pending <= 1'b0;
		end
	end

	// field slicing, reg_num and mem_addr overlap in data_a
	always_ff @(posedge clk) begin
		if (capture) begin
			instr.opcode   <= opcode_e'(data_a[1:0]);
			instr.reg_num  <= data_a[6:2];           // wbr target
			instr.mem_addr <= data_a[9:2];           // wsm word address
			instr.payload  <= data_b;                // colour or sprite record
		end
	end

	// host must wait for done before the next word pair
	a_no_strobe_while_pending: assert property (
		@(posedge clk) disable iff (!rst_n)
		pending |-> !instr_valid
	) else $error("instruction strobe dropped, previous instruction still pending");

endmodule

/* hw/control_unit.sv */
module control_unit import video_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  instr_t instr,
	input  logic   pending,                     // decoder holds an instruction
	input  logic   printing_screen,             // raster in visible lines
	output logic   reg_wr,
	output logic   mem_wr,
	output logic   done
);

	ctrl_state_e state;
	ctrl_state_e state_next;
	logic        write_slot;

	// the write goes out only while the raster is in blanking
	assign write_slot = (state == WRITE) && !printing_screen;
	assign reg_wr     = write_slot && (instr.opcode == OP_WBR);
	assign mem_wr     = write_slot && (instr.opcode == OP_WSM); // nops strobe nothing
	assign done       = (state == DONE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (pending) begin
					state_next = printing_screen ? WAIT_BLANK : WRITE; // no wait in blanking
				end
			end
			WAIT_BLANK: begin
				if (!printing_screen) begin
					state_next = WRITE;                  // blanking lasts several lines
				end
			end
			WRITE: begin
				state_next = printing_screen ? WAIT_BLANK : DONE; // frame wrapped, retry
			end
			DONE: begin
				state_next = IDLE;                       // pending drops on this edge
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	a_single_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(reg_wr && mem_wr)
	);

	// decoder keeps the instruction pending and unchanged until done
	a_instr_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state != IDLE) |-> pending && $stable(instr)
	);

endmodule

/* hw/sprite_register_file.sv */
module sprite_register_file import video_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       reg_wr,
	input  reg_num_t                   reg_num,
	input  logic [31:0]                payload,
	output color_t                     bg_color,
	output sprite_t [SPRITE_SLOTS-1:0] sprites   // all slots read in parallel
);

	// register 0 is the background, 1..4 map to slots 0..3
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bg_color <= '0;
			sprites  <= '0;                                  // every slot disabled
		end else if (reg_wr) begin
			if (reg_num == REG_BG) begin
				bg_color <= payload[8:0];
			end
			for (int i = 0; i < SPRITE_SLOTS; i++) begin
				if (reg_num == reg_num_t'(i + 1)) begin
					sprites[i] <= sprite_t'(payload[13:0]);  // x, y, image, enable
				end
			end
		end                                                  // reg_num > 4 falls through
	end

endmodule

/* hw/sprite_memory.sv */
module sprite_memory import video_pkg::*; (
	input  logic      clk,
	input  logic      mem_wr,                   // control unit owns the port
	input  mem_addr_t wr_addr,
	input  mem_addr_t rd_addr,                  // print engine fetch address
	input  color_t    wr_data,
	output color_t    rd_data                   // valid one cycle after rd_addr
);

	color_t    mem [MEM_DEPTH];                 // 4 images, 64 words each
	mem_addr_t port_addr;

	// single port, writer wins while mem_wr is high
	assign port_addr = mem_wr ? wr_addr : rd_addr;

	always_ff @(posedge clk) begin
		if (mem_wr) begin
			mem[port_addr] <= wr_data;
		end else begin
			rd_data <= mem[port_addr];          // rd_data holds during writes
		end
	end

endmodule

/* hw/raster_sync.sv */
module raster_sync import video_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	output hpos_t h_count,
	output vpos_t v_count,
	output logic  active,                       // inside 32x24 window
	output logic  hsync_raw,                    // active low
	output logic  vsync_raw,                    // active low
	output logic  printing_raw                  // visible lines
);

	hpos_t h_next;
	vpos_t v_next;

	always_comb begin
		h_next = h_count + 1'b1;
		v_next = v_count;
		if (h_count == H_LAST) begin
			h_next = '0;                                       // end of line
			v_next = (v_count == V_LAST) ? '0 : v_count + 1'b1;
		end
	end

	// flags registered together with the count they describe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			h_count      <= '0;
			v_count      <= '0;
			active       <= 1'b1;                             // decode of (0,0)
			hsync_raw    <= 1'b1;
			vsync_raw    <= 1'b1;
			printing_raw <= 1'b1;
		end else begin
			h_count      <= h_next;
			v_count      <= v_next;
			active       <= (h_next < hpos_t'(H_ACTIVE)) && (v_next < vpos_t'(V_ACTIVE));
			hsync_raw    <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_END));
			vsync_raw    <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_END));
			printing_raw <= (v_next < vpos_t'(V_ACTIVE));
		end
	end

endmodule

/* hw/print_engine.sv */
module print_engine import video_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	input  hpos_t                      h_count,
	input  vpos_t                      v_count,
	input  logic                       active,
	input  logic                       hsync_raw,
	input  logic                       vsync_raw,
	input  logic                       printing_raw,
	input  sprite_t [SPRITE_SLOTS-1:0] sprites,
	input  color_t                     bg_color,
	output mem_addr_t                  mem_rd_addr,
	input  color_t                     mem_rd_data,    // arrives with stage 2
	output logic [2:0]                 r,
	output logic [2:0]                 g,
	output logic [2:0]                 b,
	output logic                       hsync,
	output logic                       vsync,
	output logic                       printing_screen
);

	logic [6:0]              dx [SPRITE_SLOTS];      // one extra bit keeps negatives apart
	logic [5:0]              dy [SPRITE_SLOTS];
	logic [SPRITE_SLOTS-1:0] in_box;
	logic                    hit;
	logic                    hit_q;
	logic                    active_q;
	logic                    hsync_q;
	logic                    vsync_q;
	logic                    printing_q;
	color_t                  bg_q;
	color_t                  pixel;

	// per-slot offsets from the sprite origin
	always_comb begin
		for (int i = 0; i < SPRITE_SLOTS; i++) begin
			dx[i]     = {1'b0, h_count} - {1'b0, sprites[i].x};
			dy[i]     = {1'b0, v_count} - {1'b0, sprites[i].y};
			in_box[i] = sprites[i].enable && (dx[i] < 7'(SPRITE_SIZE))
				&& (dy[i] < 6'(SPRITE_SIZE));
		end
	end

	// highest slot first so the lowest hit is the last assignment
	always_comb begin
		hit         = 1'b0;
		mem_rd_addr = '0;
		for (int i = SPRITE_SLOTS - 1; i >= 0; i--) begin
			if (in_box[i]) begin
				hit         = 1'b1;
				mem_rd_addr = {sprites[i].image, dy[i][2:0], dx[i][2:0]}; // image*64 + row*8 + col
			end
		end
	end

	// stage 1, the memory's read register holds the fetch address
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hit_q      <= 1'b0;
			active_q   <= 1'b0;
			hsync_q    <= 1'b1;
			vsync_q    <= 1'b1;
			printing_q <= 1'b0;
		end else begin
			hit_q      <= hit;
			active_q   <= active;
			hsync_q    <= hsync_raw;
			vsync_q    <= vsync_raw;
			printing_q <= printing_raw;
		end
	end

	always_ff @(posedge clk) begin
		bg_q <= bg_color;                              // same pixel as hit_q
	end

	assign pixel = !active_q ? '0 : (hit_q ? mem_rd_data : bg_q); // blank outside window

	// stage 2
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{r, g, b}       <= '0;
			hsync           <= 1'b1;
			vsync           <= 1'b1;
			printing_screen <= 1'b0;
		end else begin
			{r, g, b}       <= pixel;
			hsync           <= hsync_q;
			vsync           <= vsync_q;
			printing_screen <= printing_q;
		end
	end

endmodule

/* hw/video_processor.sv */
module video_processor import video_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        instr_valid,
	input  logic [31:0] data_a,
	input  logic [31:0] data_b,
	output logic [2:0]  r,
	output logic [2:0]  g,
	output logic [2:0]  b,
	output logic        hsync,
	output logic        vsync,
	output logic        printing_screen,
	output logic        done
);

	instr_t                     instr;
	logic                       pending;
	logic                       reg_wr;
	logic                       mem_wr;
	color_t                     bg_color;
	sprite_t [SPRITE_SLOTS-1:0] sprites;
	mem_addr_t                  mem_rd_addr;
	color_t                     mem_rd_data;
	hpos_t                      h_count;
	vpos_t                      v_count;
	logic                       active;
	logic                       hsync_raw;
	logic                       vsync_raw;
	logic                       printing_raw;  // undelayed, gates the writes

	instruction_decoder u_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.data_a      (data_a),
		.data_b      (data_b),
		.instr_done  (done),
		.instr       (instr),
		.pending     (pending)
	);

	control_unit u_control (
		.clk             (clk),
		.rst_n           (rst_n),
		.instr           (instr),
		.pending         (pending),
		.printing_screen (printing_raw),   // aligned with the live count
		.reg_wr          (reg_wr),
		.mem_wr          (mem_wr),
		.done            (done)
	);

	sprite_register_file u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.reg_wr   (reg_wr),
		.reg_num  (instr.reg_num),
		.payload  (instr.payload),
		.bg_color (bg_color),
		.sprites  (sprites)
	);

	sprite_memory u_mem (
		.clk     (clk),
		.mem_wr  (mem_wr),
		.wr_addr (instr.mem_addr),
		.rd_addr (mem_rd_addr),
		.wr_data (instr.payload[8:0]),    // colour word
		.rd_data (mem_rd_data)
	);

	raster_sync u_raster (
		.clk          (clk),
		.rst_n        (rst_n),
		.h_count      (h_count),
		.v_count      (v_count),
		.active       (active),
		.hsync_raw    (hsync_raw),
		.vsync_raw    (vsync_raw),
		.printing_raw (printing_raw)
	);

	print_engine u_print (
		.clk             (clk),
		.rst_n           (rst_n),
		.h_count         (h_count),
		.v_count         (v_count),
		.active          (active),
		.hsync_raw       (hsync_raw),
		.vsync_raw       (vsync_raw),
		.printing_raw    (printing_raw),
		.sprites         (sprites),
		.bg_color        (bg_color),
		.mem_rd_addr     (mem_rd_addr),
		.mem_rd_data     (mem_rd_data),
		.r               (r),
		.g               (g),
		.b               (b),
		.hsync           (hsync),
		.vsync           (vsync),
		.printing_screen (printing_screen)
	);

endmodule

/* verification/video_checker.sv */
module video_checker import video_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            check_en,
	input  logic [8*24-1:0] test_name,
	input  logic            instr_valid,
	input  logic [31:0]     data_a,
	input  logic [31:0]     data_b,
	input  logic [2:0]      r,
	input  logic [2:0]      g,
	input  logic [2:0]      b,
	input  logic            hsync,
	input  logic            vsync,
	input  logic            printing_screen,
	input  logic            done,
	output int              error_count,
	output int              check_count
);

	typedef struct packed {
		color_t rgb;
		logic   hsync;
		logic   vsync;
		logic   printing;
	} video_out_t;

	localparam video_out_t RESET_OUT = video_out_t'({9'd0, 1'b1, 1'b1, 1'b0}); // idle outputs

	color_t      model_mem [MEM_DEPTH];                 // written before any sprite uses it
	color_t      model_bg;
	int          spr_x [SPRITE_SLOTS];
	int          spr_y [SPRITE_SLOTS];
	int          spr_img [SPRITE_SLOTS];
	bit          spr_en [SPRITE_SLOTS];
	logic [31:0] held_a;                                // word pair seen on the strobe
	logic [31:0] held_b;
	bit          held;
	int          h_pos;                                 // model raster position
	int          v_pos;
	int          age;                                   // cycles since reset, saturating
	video_out_t  exp_pipe [PIXEL_LATENCY];
	int          exp_h [PIXEL_LATENCY];                 // positions for the messages
	int          exp_v [PIXEL_LATENCY];
	video_out_t  want;

	// expected outputs for one raster position
	function automatic video_out_t expect_at(input int h, input int v);
		video_out_t o;
		int         dx;
		int         dy;
		bit         found;
		o.hsync    = !(h >= H_ACTIVE + H_FRONT && h < H_ACTIVE + H_FRONT + H_SYNC);
		o.vsync    = !(v >= V_ACTIVE + V_FRONT && v < V_ACTIVE + V_FRONT + V_SYNC);
		o.printing = (v < V_ACTIVE);
		o.rgb      = '0;                                // black outside the window
		found      = 1'b0;
		if (h < H_ACTIVE && v < V_ACTIVE) begin
			o.rgb = model_bg;
			for (int s = 0; s < SPRITE_SLOTS; s++) begin
				dx = h - spr_x[s];
				dy = v - spr_y[s];
				if (!found && spr_en[s] && dx >= 0 && dx < SPRITE_SIZE
					&& dy >= 0 && dy < SPRITE_SIZE) begin
					found = 1'b1;                       // lowest slot wins
					o.rgb = model_mem[spr_img[s] * SPRITE_SIZE * SPRITE_SIZE
						+ dy * SPRITE_SIZE + dx];
				end
			end
		end
		return o;
	endfunction

	// host word layout: a[1:0] opcode, a[6:2] register, a[9:2] memory address
	task automatic apply_instr();
		int n;
		n = int'(held_a[6:2]);
		if (held_a[1:0] == 2'd0 && n == 0) begin
			model_bg = held_b[8:0];
		end else if (held_a[1:0] == 2'd0 && n <= SPRITE_SLOTS) begin
			spr_x[n-1]   = int'(held_b[5:0]);
			spr_y[n-1]   = int'(held_b[10:6]);
			spr_img[n-1] = int'(held_b[12:11]);
			spr_en[n-1]  = held_b[13];
		end else if (held_a[1:0] == 2'd1) begin
			model_mem[held_a[9:2]] = held_b[8:0];
		end                                             // nops and registers above 4
	endtask

	task automatic compare_field(input string field, input int h, input int v,
		input logic [8:0] expected, input logic [8:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED %0s: %0s at (%0d,%0d) expected %h actual %h",
				test_name, field, h, v, expected, actual);
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			h_pos    = 0;
			v_pos    = 0;
			age      = 0;
			held     = 1'b0;
			model_bg = '0;
			for (int s = 0; s < SPRITE_SLOTS; s++) begin
				spr_en[s] = 1'b0;                       // reset disables every slot
			end
		end else begin
			if (done) begin
				if (held) begin
					apply_instr();                      // write landed this cycle
				end else begin
					error_count++;
					$display("done pulsed with no instruction outstanding");
				end
				held = 1'b0;
			end
			if (instr_valid && !held) begin
				held_a = data_a;
				held_b = data_b;
				held   = 1'b1;
			end
			want = (age < PIXEL_LATENCY) ? RESET_OUT : exp_pipe[PIXEL_LATENCY-1];
			if (check_en) begin
				check_count++;
				compare_field("rgb", exp_h[PIXEL_LATENCY-1], exp_v[PIXEL_LATENCY-1],
					want.rgb, {r, g, b});
				compare_field("hsync", exp_h[PIXEL_LATENCY-1], exp_v[PIXEL_LATENCY-1],
					9'(want.hsync), 9'(hsync));
				compare_field("vsync", exp_h[PIXEL_LATENCY-1], exp_v[PIXEL_LATENCY-1],
					9'(want.vsync), 9'(vsync));
				compare_field("printing_screen", exp_h[PIXEL_LATENCY-1],
					exp_v[PIXEL_LATENCY-1], 9'(want.printing), 9'(printing_screen));
			end
			for (int i = PIXEL_LATENCY - 1; i > 0; i--) begin
				exp_pipe[i] = exp_pipe[i-1];            // outputs trail the count
				exp_h[i]    = exp_h[i-1];
				exp_v[i]    = exp_v[i-1];
			end
			exp_pipe[0] = expect_at(h_pos, v_pos);
			exp_h[0]    = h_pos;
			exp_v[0]    = v_pos;
			if (age < PIXEL_LATENCY) begin
				age++;
			end
			h_pos++;
			if (h_pos == H_TOTAL) begin
				h_pos = 0;
				v_pos = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
			end
		end
	end

endmodule

/* verification/tb_video_processor.sv */
module tb_video_processor import video_pkg::*; ();

	localparam string TRACE_FILE   = "verification/video_trace.txt";
	localparam int    FRAME_CYCLES = H_TOTAL * V_TOTAL;     // 1120 clocks
	localparam int    DONE_LIMIT   = FRAME_CYCLES + 10;
	localparam int    MARGIN       = 4 * FRAME_CYCLES;      // reset and drain
	localparam int    FILL_WORDS   = SPRITE_SIZE * SPRITE_SIZE;

	logic            clk;
	logic            rst_n;
	logic            instr_valid;
	logic [31:0]     data_a;
	logic [31:0]     data_b;
	logic [2:0]      r;
	logic [2:0]      g;
	logic [2:0]      b;
	logic            hsync;
	logic            vsync;
	logic            printing_screen;
	logic            done;
	logic            check_en;
	logic [8*24-1:0] test_name;
	int              error_count;
	int              check_count;
	int              protocol_errors = 0;
	int              mid_frame_writes = 0;
	int              blank_writes = 0;
	int              cycle_count = 0;
	int              cycle_limit = 0;
	logic [31:0]     lcg_state = 32'hf539;

	video_processor i_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.instr_valid     (instr_valid),
		.data_a          (data_a),
		.data_b          (data_b),
		.r               (r),
		.g               (g),
		.b               (b),
		.hsync           (hsync),
		.vsync           (vsync),
		.printing_screen (printing_screen),
		.done            (done)
	);

	video_checker i_checker (
		.clk             (clk),
		.rst_n           (rst_n),
		.check_en        (check_en),
		.test_name       (test_name),
		.instr_valid     (instr_valid),
		.data_a          (data_a),
		.data_b          (data_b),
		.r               (r),
		.g               (g),
		.b               (b),
		.hsync           (hsync),
		.vsync           (vsync),
		.printing_screen (printing_screen),
		.done            (done),
		.error_count     (error_count),
		.check_count     (check_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, trace did not finish", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// one strobe, then wait for done, back at the drive point on return
	task automatic issue_instr(input logic [31:0] a, input logic [31:0] bv);
		int waited;
		bit got;
		bit in_blank;
		bit saw_print;
		in_blank  = !printing_screen;
		saw_print = 1'b0;
		if (printing_screen) begin
			mid_frame_writes++;
		end else begin
			blank_writes++;
		end
		instr_valid = 1'b1;
		data_a      = a;
		data_b      = bv;
		@(posedge clk);
		waited    = 1;
		got       = done;
		saw_print = printing_screen;
		#1 instr_valid = 1'b0;
		while (!got && waited < DONE_LIMIT) begin
			@(posedge clk);
			waited++;
			got       = done;                           // sampled before the edge updates
			saw_print = saw_print || printing_screen;   // visible lines force a wait
		end
		if (!got) begin
			protocol_errors++;
			$display("missing done for %0s after %0d cycles", test_name, waited);
		end else if (waited - 1 < 3) begin
			protocol_errors++;
			$display("done for %0s came after only %0d cycles", test_name, waited - 1);
		end else if (in_blank && !saw_print && waited - 1 > 3) begin
			protocol_errors++;
			$display("done for %0s in blanking came after %0d cycles", test_name, waited - 1);
		end
		#1;
	endtask

	// 64 words of one image, colour mixes lcg output with the address
	task automatic fill_image(input int image);
		logic [7:0] addr;
		logic [8:0] colour;
		for (int k = 0; k < FILL_WORDS; k++) begin
			addr      = 8'(image * FILL_WORDS + k);
			lcg_state = lcg_next(lcg_state);
			colour    = lcg_state[24:16] ^ {1'b0, addr};
			issue_instr({22'd0, addr, OP_WSM}, {23'd0, colour});
		end
	endtask

	// whole frames, then on into the visible lines so the next write lands mid-frame
	task automatic run_frames(input int frames);
		int waited;
		repeat (frames * FRAME_CYCLES) @(posedge clk);
		#1;
		waited = 0;
		while (!printing_screen && waited < FRAME_CYCLES) begin
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	// first pass only sums the budget, second pass drives the DUT
	task automatic process_trace(input bit execute, output int budget);
		int               fd;
		int               n;
		int               count;
		bit               more;
		logic [8*24-1:0]  kind;
		logic [8*24-1:0]  name;
		logic [8*128-1:0] line;
		logic [31:0]      word_a;
		logic [31:0]      word_b;
		budget = MARGIN;
		more   = 1'b1;
		fd     = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			protocol_errors += execute;
			$display("cannot open %0s", TRACE_FILE);
			more = 1'b0;
		end
		while (more) begin
			n = $fscanf(fd, "%s", kind);
			if (n != 1) begin
				more = 1'b0;                            // end of trace
			end else if (kind == "#") begin
				n = $fgets(line, fd);                   // column notes
			end else if (kind == "W") begin
				n      = $fscanf(fd, "%s %h %h", name, word_a, word_b);
				budget += FRAME_CYCLES;
				if (execute) begin
					test_name = name;
					issue_instr(word_a, word_b);
				end
			end else if (kind == "M") begin
				n      = $fscanf(fd, "%s %d", name, count);
				budget += FILL_WORDS * FRAME_CYCLES;
				if (execute) begin
					test_name = name;
					fill_image(count);
				end
			end else if (kind == "F") begin
				n      = $fscanf(fd, "%s %d", name, count);
				budget += (count + 1) * FRAME_CYCLES;   // plus the wait for visible lines
				if (execute) begin
					test_name = name;
					run_frames(count);
				end
			end else begin
				protocol_errors += execute;
				$display("unknown trace line kind %0s", kind);
				more = 1'b0;
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		data_a      = '0;
		data_b      = '0;
		check_en    = 1'b0;
		test_name   = "reset";
		process_trace(1'b0, cycle_limit);
		repeat (4) @(posedge clk);
		#1;
		rst_n    = 1'b1;
		check_en = 1'b1;                                // compare from the first cycle on
		process_trace(1'b1, cycle_limit);
		repeat (PIXEL_LATENCY + 2) @(posedge clk);
		if (check_count == 0) begin
			protocol_errors++;
			$display("no output cycles were compared");
		end
		if (mid_frame_writes == 0 || blank_writes == 0) begin
			protocol_errors++;
			$display("writes did not cover both mid-frame and blanking");
		end
		$display("errors: pixel=%0d protocol=%0d over %0d compared cycles",
			error_count, protocol_errors, check_count);
		if (error_count == 0 && protocol_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* verification/video_trace.txt */
# W name data_a data_b (hex) | M name image (fills 64 words) | F name frames
# data_a[1:0] opcode, [6:2] register or [9:2] word address; data_b colour or sprite record
F sync_after_reset 1
W bg_write 00000000 000001a5
F background 2
M fill_image1 1
M fill_image2 2
W edge_slot0 00000004 00002d1c
W edge_slot3 00000010 00002800
F edge_draw 1
W interior_slot0 00000004 00002a0a
F interior_draw 1
W overlap_slot1 00000008 000032ce
F priority 2
W mem_midframe 00000215 000000f0
F mem_update 1
W disable_slot0 00000004 00000a0a
F disable 1
W reg5_ignored 00000014 000001ff
W reg31_ignored 0000007c 00003fff
F out_of_range 1
W nop2 00000002 00003fff
W nop3 0000007f 0000ffff
F nop 1
W bg_change 00000000 00000038
W disable_slot3 00000010 00000000
F final 2

/* video_processor.f */
hw/video_pkg.sv
hw/instruction_decoder.sv
hw/control_unit.sv
hw/sprite_register_file.sv
hw/sprite_memory.sv
hw/raster_sync.sv
hw/print_engine.sv
hw/video_processor.sv
verification/video_checker.sv
verification/tb_video_processor.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the video processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_video_processor -f video_processor.f \
	-Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi
exit 0
